//--- source/sha_miner_cfg.svh
// Build-time knobs for the miner; press and quiet counts must stay below the long count
`ifndef SHA_MINER_CFG_SVH
`define SHA_MINER_CFG_SVH

////////////////////////////////////////////////////////////
// Fire button timing in clk cycles
////////////////////////////////////////////////////////////

// Stable high samples before a press is taken
`define SHA_DB_PRESS_CYCLES 8

// Total held samples before the press turns long
// Also sets the debounce counter width
`define SHA_DB_LONG_CYCLES 64

// Stable low samples to finish a release
`define SHA_DB_QUIET_CYCLES 16

////////////////////////////////////////////////////////////
// Search settings
////////////////////////////////////////////////////////////

// Leading zero bits of digest word 7 that count as a hit
`define SHA_HIT_ZERO_BITS 4

// Counting part of the nonce, 1 to 31 bits
`define SHA_NONCE_INC_BITS 20

`endif

//--- source/sha_miner_pkg.sv
// Shared types and SHA-256 constants for the RTL and the model with header byte 0 in the top bits
package sha_miner_pkg;

	typedef logic [0:79][7:0] header_t;  // Byte 0 most significant, nonce in bytes 76..79
	typedef logic [0:15][31:0] block_t;  // Big endian message words
	typedef logic [0:7][31:0] digest_t;  // Word 0 is H0

	typedef enum logic [1:0] {
		JOB_MIDSTATE,  // Header block 0 from IV
		JOB_NONCE,     // Header block 1 from midstate
		JOB_FINAL      // Second hash of first digest
	} job_e;

	typedef enum logic {
		SEQ_IDLE,
		SEQ_BUSY       // One job in the core
	} seq_state_e;

	typedef enum logic [2:0] {
		DB_IDLE,
		DB_WAIT_PRESS,
		DB_WAIT_LONG,
		DB_LONG,
		DB_WAIT_OFF
	} db_state_e;

	typedef struct packed {
		logic valid;      // One cycle per double hash
		logic hit;
		logic [31:0] nonce;
		digest_t digest;  // Final digest
	} result_t;

	// FIPS 180-4 round constants
	localparam logic [0:63][31:0] SHA_K = {
		32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5, 32'h3956c25b, 32'h59f111f1,
		32'h923f82a4, 32'hab1c5ed5, 32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
		32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174, 32'he49b69c1, 32'hefbe4786,
		32'h0fc19dc6, 32'h240ca1cc, 32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
		32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7, 32'hc6e00bf3, 32'hd5a79147,
		32'h06ca6351, 32'h14292967, 32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
		32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85, 32'ha2bfe8a1, 32'ha81a664b,
		32'hc24b8b70, 32'hc76c51a3, 32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
		32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5, 32'h391c0cb3, 32'h4ed8aa4a,
		32'h5b9cca4f, 32'h682e6ff3, 32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
		32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
	};

	// Initial hash value
	localparam digest_t SHA_IV = {
		32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
		32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
	};

endpackage

//--- source/sha256_compress.sv
// One round per cycle SHA-256 compression; done comes 65 cycles after start, no start while busy
module sha256_compress import sha_miner_pkg::*; (
	input  logic    clk,
	input  logic    reset,
	input  logic    i_start,   // Samples block and chain
	input  block_t  i_block,
	input  digest_t i_chain,
	output logic    o_done,    // One cycle pulse
	output digest_t o_state    // Valid with o_done
);

	digest_t chain;     // Chaining value kept for the final add
	digest_t work;      // Working vars a..h
	block_t win;        // Rolling schedule, win[0] is W[t]
	logic busy;
	logic [5:0] rnd;    // Round index t
	logic [31:0] big_s0;
	logic [31:0] big_s1;
	logic [31:0] ch;
	logic [31:0] maj;
	logic [31:0] t1;
	logic [31:0] t2;
	logic [31:0] sml_s0;
	logic [31:0] sml_s1;
	logic [31:0] w_next;

	function automatic logic [31:0] rotr(input logic [31:0] x, input int unsigned n);
		return (x >> n) | (x << (32 - n));
	endfunction

	////////////////////////////////////////////////////////////
	// Round and schedule math
	////////////////////////////////////////////////////////////

	always_comb begin
		big_s1 = rotr(work[4], 6) ^ rotr(work[4], 11) ^ rotr(work[4], 25);
		ch = (work[4] & work[5]) ^ (~work[4] & work[6]);  // Choose on e
		t1 = work[7] + big_s1 + ch + SHA_K[rnd] + win[0];
		big_s0 = rotr(work[0], 2) ^ rotr(work[0], 13) ^ rotr(work[0], 22);
		maj = (work[0] & work[1]) ^ (work[0] & work[2]) ^ (work[1] & work[2]);
		t2 = big_s0 + maj;

		// W[t+16] from the window
		sml_s0 = rotr(win[1], 7) ^ rotr(win[1], 18) ^ (win[1] >> 3);
		sml_s1 = rotr(win[14], 17) ^ rotr(win[14], 19) ^ (win[14] >> 10);
		w_next = sml_s1 + win[9] + sml_s0 + win[0];

		// Feed forward
		for (int i = 0; i < 8; i++)
			o_state[i] = chain[i] + work[i];
	end

	////////////////////////////////////////////////////////////
	// Datapath registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (i_start) begin
			chain <= i_chain;
			work <= i_chain;
			win <= i_block;  // First 16 words as given
		end else if (busy) begin
			work <= {t1 + t2, work[0], work[1], work[2], work[3] + t1, work[4], work[5], work[6]};
			win <= {win[1:15], w_next};
		end
	end

	////////////////////////////////////////////////////////////
	// Round control
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			rnd <= '0;
			o_done <= 1'b0;
		end else begin
			o_done <= busy && (rnd == 6'd63);  // Last round lands this edge
			if (i_start) begin
				busy <= 1'b1;
				rnd <= '0;
			end else if (busy) begin
				rnd <= rnd + 6'd1;
				if (rnd == 6'd63)
					busy <= 1'b0;
			end
		end
	end

endmodule

//--- source/button_debounce.sv
// Button filter with 2-flop sync; a press pulse comes a cycle after the count, long holds till release
`include "sha_miner_cfg.svh"

module button_debounce import sha_miner_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic i_button,  // Async, active high
	output logic o_press,   // One cycle pulse
	output logic o_long     // Level while held long
);

	localparam int CNT_W = $clog2(`SHA_DB_LONG_CYCLES + 1);
	localparam logic [CNT_W-1:0] PRESS_LAST = CNT_W'(`SHA_DB_PRESS_CYCLES - 1);
	localparam logic [CNT_W-1:0] LONG_LAST = CNT_W'(`SHA_DB_LONG_CYCLES - 1);
	localparam logic [CNT_W-1:0] QUIET_LAST = CNT_W'(`SHA_DB_QUIET_CYCLES - 1);

	logic [1:0] sync;        // Metastability chain
	logic btn;
	db_state_e state;
	logic [CNT_W-1:0] cnt;   // Samples in the current level

	assign btn = sync[1];
	assign o_long = (state == DB_LONG);

	always_ff @(posedge clk) begin
		if (reset) begin
			sync <= '0;
			state <= DB_IDLE;
			cnt <= '0;
			o_press <= 1'b0;
		end else begin
			sync <= {sync[0], i_button};
			o_press <= 1'b0;
			cnt <= cnt + 1'b1;  // Default keeps counting
			case (state)
				DB_IDLE: begin
					cnt <= CNT_W'(1);  // First high sample counts
					if (btn)
						state <= DB_WAIT_PRESS;
				end
				DB_WAIT_PRESS: begin
					if (!btn) begin
						state <= DB_IDLE;  // Short bounce dropped
					end else if (cnt == PRESS_LAST) begin
						o_press <= 1'b1;
						state <= DB_WAIT_LONG;
					end
				end
				DB_WAIT_LONG: begin
					if (!btn) begin
						cnt <= CNT_W'(1);
						state <= DB_WAIT_OFF;
					end else if (cnt == LONG_LAST) begin
						state <= DB_LONG;
					end
				end
				DB_LONG: begin
					cnt <= CNT_W'(1);  // Parked until release
					if (!btn)
						state <= DB_WAIT_OFF;
				end
				default: begin  // DB_WAIT_OFF
					if (btn)
						cnt <= '0;  // Release bounce restarts the quiet time
					else if (cnt == QUIET_LAST)
						state <= DB_IDLE;
				end
			endcase
		end
	end

endmodule

//--- source/miner_sequencer.sv
// Job issue FSM for single and continuous runs; o_job changes only on core done or from idle
module miner_sequencer import sha_miner_pkg::*; (
	input  logic clk,
	input  logic reset,
	input  logic i_press,      // Short press pulse
	input  logic i_long,       // Long hold level
	input  logic i_final_hit,  // Same cycle as final done
	input  logic i_core_done,
	output logic o_job_start,  // One cycle pulse
	output job_e o_job,
	output logic o_continuous
);

	seq_state_e state;
	logic long_q;     // Edge detect on long hold
	logic cont_next;
	logic go;         // Run request from idle

	// Continuous mode, a hit beats everything
	always_comb begin
		cont_next = o_continuous;
		if (i_final_hit)
			cont_next = 1'b0;
		else if (i_long && !long_q)
			cont_next = 1'b1;
		else if (i_press && o_continuous)
			cont_next = 1'b0;  // Short press stops the search
	end

	// Press starts a run, unless it is stopping continuous mode
	assign go = o_continuous ? !i_press : i_press;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			o_job_start <= 1'b0;
			o_job <= JOB_MIDSTATE;
			o_continuous <= 1'b0;
			long_q <= 1'b0;
		end else begin
			long_q <= i_long;
			o_continuous <= cont_next;
			o_job_start <= 1'b0;
			case (state)
				SEQ_IDLE: begin
					if (go) begin
						o_job <= JOB_MIDSTATE;  // Fresh midstate every run
						o_job_start <= 1'b1;
						state <= SEQ_BUSY;
					end
				end
				default: begin  // SEQ_BUSY
					if (i_core_done) begin
						case (o_job)
							JOB_MIDSTATE: begin
								o_job <= JOB_NONCE;
								o_job_start <= 1'b1;
							end
							JOB_NONCE: begin
								o_job <= JOB_FINAL;
								o_job_start <= 1'b1;
							end
							default: begin  // JOB_FINAL closes a pair
								if (cont_next) begin
									o_job <= JOB_NONCE;  // Next nonce reuses midstate
									o_job_start <= 1'b1;
								end else begin
									state <= SEQ_IDLE;
								end
							end
						endcase
					end
				end
			endcase
		end
	end

endmodule

//--- source/work_builder.sv
// Block and chain select per job; nonce k since reset is header nonce plus k in the counting bits
`include "sha_miner_cfg.svh"

module work_builder import sha_miner_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  header_t     i_header,
	input  logic        i_job_start,
	input  job_e        i_job,        // Held through the job
	input  logic        i_core_done,
	input  digest_t     i_core_state,
	output logic        o_start,      // One cycle after job start
	output block_t      o_block,
	output digest_t     o_chain,
	output logic [31:0] o_nonce
);

	localparam int NB = `SHA_NONCE_INC_BITS;

	logic [639:0] hdr_bits;
	logic [31:0] hdr_nonce;   // Nonce field, little endian bytes
	logic [31:0] nonce_word;  // Nonce back in header byte order
	logic [NB-1:0] nonce_ofs; // Pairs done since reset
	digest_t midstate;
	digest_t first_hash;

	assign hdr_bits = i_header;
	assign hdr_nonce = {i_header[79], i_header[78], i_header[77], i_header[76]};
	assign o_nonce = {hdr_nonce[31:NB], hdr_nonce[NB-1:0] + nonce_ofs};  // High bits fixed
	assign nonce_word = {o_nonce[7:0], o_nonce[15:8], o_nonce[23:16], o_nonce[31:24]};

	always_ff @(posedge clk) begin
		if (i_core_done && i_job == JOB_MIDSTATE)
			midstate <= i_core_state;
		if (i_core_done && i_job == JOB_NONCE)
			first_hash <= i_core_state;
		if (reset) begin
			o_start <= 1'b0;
			nonce_ofs <= '0;
		end else begin
			o_start <= i_job_start;
			if (i_core_done && i_job == JOB_FINAL)
				nonce_ofs <= nonce_ofs + 1'b1;  // Wraps inside the counting bits
		end
	end

	always_comb begin
		case (i_job)
			JOB_MIDSTATE: begin
				o_block = hdr_bits[639:128];  // Bytes 0..63
				o_chain = SHA_IV;
			end
			JOB_NONCE: begin
				// Bytes 64..79, pad bit, length 640
				o_block = {hdr_bits[127:32], nonce_word, 32'h80000000, 320'h0, 32'h00000280};
				o_chain = midstate;
			end
			default: begin  // JOB_FINAL
				o_block = {first_hash, 32'h80000000, 192'h0, 32'h00000100};  // Length 256
				o_chain = SHA_IV;
			end
		endcase
	end

endmodule

//--- source/result_capture.sv
// Result and hit tracking on final done; o_result.valid pulses one cycle, other fields hold
`include "sha_miner_cfg.svh"

module result_capture import sha_miner_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  job_e        i_job,
	input  logic        i_core_done,
	input  digest_t     i_core_state,
	input  logic [31:0] i_nonce,      // Nonce of the pair in flight
	output logic        o_final_hit,  // Same cycle as final done
	output result_t     o_result,
	output logic [31:0] o_hit_nonce,
	output logic [31:0] o_op_count
);

	logic final_done;
	logic hit_now;

	assign final_done = i_core_done && (i_job == JOB_FINAL);
	// Leading bits of word 7 all zero
	assign hit_now = (i_core_state[7][31 -: `SHA_HIT_ZERO_BITS] == '0);
	assign o_final_hit = final_done && hit_now;

	always_ff @(posedge clk) begin
		if (final_done) begin
			o_result.hit <= hit_now;
			o_result.nonce <= i_nonce;
			o_result.digest <= i_core_state;
		end
		if (reset) begin
			o_result.valid <= 1'b0;
			o_hit_nonce <= '0;
			o_op_count <= '0;
		end else begin
			o_result.valid <= final_done;
			if (final_done)
				o_op_count <= o_op_count + 32'd1;  // One per double hash
			if (o_final_hit)
				o_hit_nonce <= i_nonce;
		end
	end

endmodule

//--- source/sha_miner_top.sv
// Miner top with one shared SHA-256 core; i_header may only change while no run is active
module sha_miner_top import sha_miner_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic        i_fire_button,  // Raw async button
	input  header_t     i_header,
	output result_t     o_result,
	output logic [31:0] o_hit_nonce,
	output logic        o_continuous,
	output logic [31:0] o_op_count
);

	logic press;        // One cycle per short press
	logic long_hold;    // High while held long
	logic job_start;
	job_e job;          // Stable until core done
	logic final_hit;
	logic core_start;
	logic core_done;
	block_t core_block;
	digest_t core_chain;
	digest_t core_state;
	logic [31:0] nonce; // Nonce of the current pair

	////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////

	button_debounce u_button_debounce (
		.clk      (clk),
		.reset    (reset),
		.i_button (i_fire_button),
		.o_press  (press),
		.o_long   (long_hold)
	);

	miner_sequencer u_miner_sequencer (
		.clk          (clk),
		.reset        (reset),
		.i_press      (press),
		.i_long       (long_hold),
		.i_final_hit  (final_hit),
		.i_core_done  (core_done),
		.o_job_start  (job_start),
		.o_job        (job),
		.o_continuous (o_continuous)
	);

	////////////////////////////////////////////////////////////
	// Datapath
	////////////////////////////////////////////////////////////

	work_builder u_work_builder (
		.clk          (clk),
		.reset        (reset),
		.i_header     (i_header),
		.i_job_start  (job_start),
		.i_job        (job),
		.i_core_done  (core_done),
		.i_core_state (core_state),
		.o_start      (core_start),
		.o_block      (core_block),
		.o_chain      (core_chain),
		.o_nonce      (nonce)
	);

	sha256_compress u_sha256_compress (
		.clk     (clk),
		.reset   (reset),
		.i_start (core_start),
		.i_block (core_block),
		.i_chain (core_chain),
		.o_done  (core_done),
		.o_state (core_state)
	);

	result_capture u_result_capture (
		.clk          (clk),
		.reset        (reset),
		.i_job        (job),
		.i_core_done  (core_done),
		.i_core_state (core_state),
		.i_nonce      (nonce),
		.o_final_hit  (final_hit),
		.o_result     (o_result),
		.o_hit_nonce  (o_hit_nonce),
		.o_op_count   (o_op_count)
	);

endmodule

//--- dv/sha256_model.svh
// Reference SHA-256 for the testbench; needs sha_miner_pkg imported and the cfg header included
`ifndef SHA256_MODEL_SVH
`define SHA256_MODEL_SVH

function automatic logic [31:0] ror32(logic [31:0] x, int n);
	return (x >> n) | (x << (32 - n));
endfunction

// Plain FIPS 180-4 compression with the full 64-word schedule
function automatic digest_t model_compress(digest_t chain, block_t blk);
	logic [31:0] w [0:63];
	logic [31:0] v [0:7];  // a..h
	logic [31:0] s0;
	logic [31:0] s1;
	logic [31:0] t1;
	logic [31:0] t2;
	digest_t res;
	for (int t = 0; t < 16; t++)
		w[t] = blk[t];
	for (int t = 16; t < 64; t++) begin
		s0 = ror32(w[t-15], 7) ^ ror32(w[t-15], 18) ^ (w[t-15] >> 3);
		s1 = ror32(w[t-2], 17) ^ ror32(w[t-2], 19) ^ (w[t-2] >> 10);
		w[t] = w[t-16] + s0 + w[t-7] + s1;
	end
	for (int i = 0; i < 8; i++)
		v[i] = chain[i];
	for (int t = 0; t < 64; t++) begin
		s1 = ror32(v[4], 6) ^ ror32(v[4], 11) ^ ror32(v[4], 25);
		t1 = v[7] + s1 + ((v[4] & v[5]) ^ (~v[4] & v[6])) + SHA_K[t] + w[t];
		s0 = ror32(v[0], 2) ^ ror32(v[0], 13) ^ ror32(v[0], 22);
		t2 = s0 + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
		for (int i = 7; i > 0; i--)
			v[i] = v[i-1];
		v[4] = v[4] + t1;  // e = d + t1
		v[0] = t1 + t2;
	end
	for (int i = 0; i < 8; i++)
		res[i] = chain[i] + v[i];
	return res;
endfunction

// 64 message bytes into big endian words
function automatic block_t pack_block(logic [7:0] b [0:63]);
	block_t blk;
	for (int j = 0; j < 16; j++)
		blk[j] = {b[4*j], b[4*j+1], b[4*j+2], b[4*j+3]};
	return blk;
endfunction

function automatic logic [31:0] header_nonce(header_t h);
	return {h[79], h[78], h[77], h[76]};  // Little endian field
endfunction

// Nonce of result k since reset, counting bits wrap
function automatic logic [31:0] nonce_for(header_t h, int k);
	logic [31:0] mask;
	logic [31:0] hn;
	mask = (32'd1 << `SHA_NONCE_INC_BITS) - 32'd1;
	hn = header_nonce(h);
	return (hn & ~mask) | ((hn + 32'(k)) & mask);
endfunction

// SHA-256 of the 80-byte header, then SHA-256 of that digest
function automatic digest_t double_hash(header_t h, logic [31:0] nonce);
	logic [7:0] b [0:63];
	digest_t mid;
	digest_t first;
	for (int i = 0; i < 64; i++)
		b[i] = h[i];
	mid = model_compress(SHA_IV, pack_block(b));
	for (int i = 0; i < 64; i++)
		b[i] = 8'h00;
	for (int i = 0; i < 12; i++)
		b[i] = h[64 + i];
	for (int i = 0; i < 4; i++)
		b[12 + i] = nonce[8*i +: 8];  // LSB first
	b[16] = 8'h80;
	b[62] = 8'h02;  // 640 bits
	b[63] = 8'h80;
	first = model_compress(mid, pack_block(b));
	for (int i = 0; i < 64; i++)
		b[i] = 8'h00;
	for (int i = 0; i < 32; i++)
		b[i] = 8'(first[i / 4] >> (24 - 8 * (i % 4)));
	b[32] = 8'h80;
	b[62] = 8'h01;  // 256 bits
	return model_compress(SHA_IV, pack_block(b));
endfunction

function automatic bit is_hit(digest_t d);
	return (d[7] >> (32 - `SHA_HIT_ZERO_BITS)) == 32'd0;
endfunction

`endif

//--- dv/sha_miner_tb.sv
// Miner testbench; headers come from an LCG and the hit searches run in the model in zero sim time
`include "sha_miner_cfg.svh"

module sha_miner_tb import sha_miner_pkg::*;;

	localparam int SHORT_HOLD = `SHA_DB_PRESS_CYCLES + 6;
	localparam int LONG_HOLD = `SHA_DB_LONG_CYCLES + 16;
	localparam int QUIET_WAIT = `SHA_DB_QUIET_CYCLES + 8;
	localparam int BOUNCE_HOLD = `SHA_DB_PRESS_CYCLES - 1;  // One sample too short to count
	localparam int IDLE_WAIT = 300;  // Longer than a whole run
	localparam int N_SEQ = 3;
	localparam int HIT_SPAN = 16;
	localparam int FREE_SPAN = 32;
	localparam int STOP_AFTER = 3;
	localparam int N_RESULTS = 1 + N_SEQ + HIT_SPAN + STOP_AFTER + 2;
	localparam int N_PRESSES = 8;
	localparam int TIMEOUT = N_RESULTS * 140 + N_PRESSES * 150 + 8 * IDLE_WAIT + 2000;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic fire = 1'b0;
	header_t header = '0;
	result_t result;
	logic [31:0] hit_nonce;
	logic continuous;
	logic [31:0] op_count;

	string test_name = "reset";
	int result_count = 0;  // Also the nonce index
	int stop_count = 0;    // Results seen when continuous fell
	int fail_count = 0;
	int cycle_count = 0;
	logic cont_q = 1'b0;
	logic [31:0] lcg_state = 32'd44;

	`include "sha256_model.svh"

	sha_miner_top u_sha_miner_top (
		.clk            (clk),
		.reset          (reset),
		.i_fire_button  (fire),
		.i_header       (header),
		.o_result       (result),
		.o_hit_nonce    (hit_nonce),
		.o_continuous   (continuous),
		.o_op_count     (op_count)
	);

	always #2 clk = ~clk;

	////////////////////////////////////////////////////////////
	// Checks and helpers
	////////////////////////////////////////////////////////////

	task automatic fail_now(string why);
		fail_count++;
		$display("%s", why);
		$display("Test failures found");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_eq(string what, logic [255:0] exp, logic [255:0] act);
		assert (exp == act)
		else fail_now($sformatf("MISMATCH %s %s expected %0h actual %0h",
			test_name, what, exp, act));
	endtask

	task automatic check_true(bit cond, string why);
		assert (cond)
		else fail_now($sformatf("%s: %s", test_name, why));
	endtask

	function automatic logic [7:0] lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16];  // Upper bits have the longer period
	endfunction

	function automatic header_t random_header();
		header_t h;
		for (int i = 0; i < 80; i++)
			h[i] = lcg_byte();
		return h;
	endfunction

	function automatic header_t with_nonce(header_t h, logic [31:0] n);
		header_t r;
		r = h;
		for (int i = 0; i < 4; i++)
			r[76 + i] = n[8*i +: 8];
		return r;
	endfunction

	// Index of the first hit from result k0 or -1 when there is none
	function automatic int first_hit(header_t h, int k0, int span);
		for (int j = 0; j < span; j++)
			if (is_hit(double_hash(h, nonce_for(h, k0 + j))))
				return j;
		return -1;
	endfunction

	task automatic hold_button(int cycles);
		fire <= 1'b1;
		repeat (cycles) @(posedge clk);
		fire <= 1'b0;
	endtask

	task automatic short_press();
		hold_button(SHORT_HOLD);
		repeat (QUIET_WAIT) @(posedge clk);  // Release settles
	endtask

	task automatic wait_results(int target);
		int waited = 0;
		int limit = (target - result_count) * 140 + IDLE_WAIT;
		while (result_count < target && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		check_true(result_count >= target, $sformatf("result %0d never arrived", target));
	endtask

	task automatic wait_continuous_low(int limit);
		int waited = 0;
		while (continuous && waited < limit) begin
			@(posedge clk);
			waited++;
		end
		check_true(!continuous, "continuous mode did not end");
	endtask

	////////////////////////////////////////////////////////////
	// Result monitor sampling away from the clock edge
	////////////////////////////////////////////////////////////

	always @(negedge clk) begin
		digest_t exp_d;
		logic [31:0] exp_n;
		if (!reset) begin
			if (cont_q && !continuous)
				stop_count = result_count;  // Before this cycle's result
			cont_q = continuous;
			if (result.valid) begin
				exp_n = nonce_for(header, result_count);
				exp_d = double_hash(header, exp_n);
				check_eq("nonce", 256'(exp_n), 256'(result.nonce));
				check_eq("digest", exp_d, result.digest);
				check_eq("hit flag", 256'(is_hit(exp_d)), 256'(result.hit));
				if (result.hit) begin
					check_eq("hit nonce", 256'(exp_n), 256'(hit_nonce));
				end
				result_count++;
			end
			check_eq("operation count", 256'(result_count), 256'(op_count));
		end
	end

	initial begin
		while (cycle_count < TIMEOUT) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("Run hit the %0d cycle limit in test %s", cycle_count, test_name);
		$display("Test failures found");
		$fatal(1, "timeout");
	end

	////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////

	initial begin
		header_t h;
		logic [31:0] mask;
		logic [31:0] hn;
		int k0;
		int fh;
		int tries;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);

		// Idle outputs and an ignored bounce
		test_name = "reset_bounce";
		check_true(!result.valid && !continuous && op_count == 32'd0, "outputs not idle");
		header <= random_header();
		hold_button(BOUNCE_HOLD);
		repeat (IDLE_WAIT) @(posedge clk);
		check_true(result_count == 0, "short bounce started a run");

		test_name = "single_press";
		short_press();
		wait_results(1);
		repeat (IDLE_WAIT) @(posedge clk);
		check_true(result_count == 1, "one press gave extra results");

		// Low bits two below wrap so the third result lands on zero
		test_name = "press_sequence";
		k0 = result_count;
		mask = (32'd1 << `SHA_NONCE_INC_BITS) - 32'd1;
		h = random_header();
		hn = header_nonce(h);
		hn = (hn & ~mask) | ((mask - 32'd1 - 32'(k0)) & mask);
		header <= with_nonce(h, hn);
		for (int i = 0; i < N_SEQ; i++) begin
			short_press();
			wait_results(k0 + i + 1);
			repeat (IDLE_WAIT) @(posedge clk);
			check_true(result_count == k0 + i + 1, "short press gave extra results");
		end
		check_eq("wrapped nonce", 256'(hn & ~mask), 256'(result.nonce));

		// Header whose first hit comes a few nonces in
		test_name = "continuous_hit";
		k0 = result_count;
		tries = 0;
		fh = -1;
		while (fh < 2 && tries < 200) begin
			h = random_header();
			fh = first_hit(h, k0, HIT_SPAN);
			tries++;
		end
		check_true(fh >= 2, "no header with an early hit found");
		header <= h;
		hold_button(LONG_HOLD);
		check_true(continuous, "long press did not set continuous mode");
		wait_results(k0 + fh + 1);
		wait_continuous_low(8);
		repeat (IDLE_WAIT) @(posedge clk);
		check_true(result_count == k0 + fh + 1, "results went on after the hit");
		check_eq("latched hit nonce", 256'(nonce_for(h, k0 + fh)), 256'(hit_nonce));

		// Hit-free header stopped by a short press
		test_name = "continuous_stop";
		k0 = result_count;
		tries = 0;
		fh = 0;
		while (fh >= 0 && tries < 200) begin
			h = random_header();
			fh = first_hit(h, k0, FREE_SPAN);
			tries++;
		end
		check_true(fh < 0, "no hit-free header found");
		header <= h;
		hold_button(LONG_HOLD);
		repeat (QUIET_WAIT) @(posedge clk);
		wait_results(k0 + STOP_AFTER);
		check_true(continuous, "continuous mode ended without a hit");
		short_press();
		wait_continuous_low(IDLE_WAIT);
		repeat (IDLE_WAIT) @(posedge clk);
		check_true(result_count <= stop_count + 1, "more than one result after the stop");

		test_name = "op_count";
		check_eq("final operation count", 256'(result_count), 256'(op_count));
		if (fail_count == 0) begin
			$display("All tests passed!");
			$finish;
		end else begin
			$display("Test failures found");
			$fatal(1, "checks failed");
		end
	end

endmodule

//--- build.f
+incdir+source
+incdir+dv
source/sha_miner_pkg.sv
source/sha256_compress.sv
source/button_debounce.sv
source/miner_sequencer.sv
source/work_builder.sv
source/result_capture.sv
source/sha_miner_top.sv
dv/sha_miner_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the miner testbench with Verilator; exit status is the test result
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --assert -j 0 --top-module sha_miner_tb -f build.f -o sha_miner_sim
./obj_dir/sha_miner_sim
